/* cal_pkg.sv */
package cal_pkg;

    localparam int BUTTON_COUNT = 5;

    // Lower index wins when presses coincide
    localparam int BTN_UP    = 0;
    localparam int BTN_DOWN  = 1;
    localparam int BTN_LEFT  = 2;
    localparam int BTN_RIGHT = 3;
    localparam int BTN_MID   = 4;

    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES);

    localparam int OP_COUNT     = 4;
    localparam int RESULT_WIDTH = 24;

    typedef logic [DEBOUNCE_CNT_W-1:0] debounce_cnt_t;
    localparam debounce_cnt_t DEBOUNCE_LAST = debounce_cnt_t'(DEBOUNCE_CYCLES - 1);

    typedef logic [3:0]              bcd_digit_t;
    // Sign on top, then digit 2, digit 1, digit 0
    typedef logic [12:0]             bcd_operand_t;
    // Bit 0 add, 1 subtract, 2 multiply, 3 divide
    typedef logic [OP_COUNT-1:0]     op_sel_t;
    typedef logic [RESULT_WIDTH-1:0] result_t;
    typedef logic [3:0]              digit_sel_t;
    typedef logic [7:0]              seg_t;

    localparam seg_t SEG_DIGITS [10] = '{
        8'b1111_1100, 8'b0110_0000, 8'b1101_1010, 8'b1111_0010, 8'b0110_0110,
        8'b1011_0110, 8'b1011_1110, 8'b1110_0000, 8'b1111_1110, 8'b1110_0110
    };
    localparam seg_t SEG_DOT   = 8'b0000_0001;
    localparam seg_t SEG_BLANK = 8'b0000_0000;

    typedef enum logic [2:0] {
        CTRL_IDLE, CTRL_INPUT_A, CTRL_INPUT_B, CTRL_EXEC, CTRL_DISPLAY
    } ctrl_state_t;

    typedef enum logic [2:0] {
        POS_IDLE, POS_DIGIT0, POS_DIGIT1, POS_DIGIT2, POS_SIGN
    } pos_state_t;

    typedef enum logic [1:0] {
        EXEC_IDLE, EXEC_INIT, EXEC_SINGLE, EXEC_DONE
    } exec_state_t;

endpackage

/* cal_if.sv */
// One-cycle button pulses, at most one high at a time
interface button_if;
    logic up;
    logic down;
    logic left;
    logic right;
    logic mid;

    modport source (output up, down, left, right, mid);
    modport sink   (input  up, down, left, right, mid);
endinterface

interface entry_if;
    logic entry_active;
    logic entry_restart;
    logic capture_a;
    logic capture_b;

    modport source (output entry_active, entry_restart, capture_a, capture_b);
    modport sink   (input  entry_active, entry_restart, capture_a, capture_b);
endinterface

// Four-phase req/ack between control and execution
interface exec_if;
    import cal_pkg::*;

    logic         req;
    logic         ack;
    bcd_operand_t operand_a;
    bcd_operand_t operand_b;

    modport requester (output req, input ack);
    modport operands  (output operand_a, operand_b);
    modport responder (input req, operand_a, operand_b, output ack);
endinterface

/* button_input.sv */
module button_input (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cal_pkg::BUTTON_COUNT-1:0] raw_buttons,
    button_if.source                        btn
);
    import cal_pkg::*;

    logic [BUTTON_COUNT-1:0] raw_meta;
    logic [BUTTON_COUNT-1:0] raw_sync;
    logic [BUTTON_COUNT-1:0] level;
    logic [BUTTON_COUNT-1:0] press;
    logic [BUTTON_COUNT-1:0] press_first;
    debounce_cnt_t           stable_cnt [BUTTON_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_meta <= '0;
            raw_sync <= '0;
            level    <= '0;
            press    <= '0;
            for (int i = 0; i < BUTTON_COUNT; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            raw_meta <= raw_buttons;
            raw_sync <= raw_meta;
            for (int i = 0; i < BUTTON_COUNT; i++) begin
                press[i] <= 1'b0;
                // Any bounce back to the old level restarts the count
                if (raw_sync[i] == level[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == DEBOUNCE_LAST) begin
                    stable_cnt[i] <= '0;
                    level[i]      <= raw_sync[i];
                    press[i]      <= raw_sync[i];
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // Keep only the lowest set bit
    assign press_first = press & (~press + 1'b1);

    assign btn.up    = press_first[BTN_UP];
    assign btn.down  = press_first[BTN_DOWN];
    assign btn.left  = press_first[BTN_LEFT];
    assign btn.right = press_first[BTN_RIGHT];
    assign btn.mid   = press_first[BTN_MID];

endmodule

/* cal_control.sv */
module cal_control (
    input  logic     clk,
    input  logic     rst_n,
    button_if.sink   btn,
    entry_if.source  entry,
    exec_if.requester exec,
    output logic     exe_done
);
    import cal_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            CTRL_IDLE: begin
                state_next = CTRL_INPUT_A;
            end
            CTRL_INPUT_A: begin
                if (btn.mid) state_next = CTRL_INPUT_B;
            end
            CTRL_INPUT_B: begin
                if (btn.mid) state_next = CTRL_EXEC;
            end
            CTRL_EXEC: begin
                if (exec.ack) state_next = CTRL_DISPLAY;
            end
            CTRL_DISPLAY: begin
                if (btn.mid) state_next = CTRL_INPUT_A;
            end
            default: begin
                state_next = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Entry events fire in the transition cycle
    assign entry.entry_active  = (state == CTRL_INPUT_A) || (state == CTRL_INPUT_B);
    assign entry.entry_restart = (state != CTRL_INPUT_A) && (state_next == CTRL_INPUT_A);
    assign entry.capture_a     = (state == CTRL_INPUT_A) && (state_next == CTRL_INPUT_B);
    assign entry.capture_b     = (state == CTRL_INPUT_B) && (state_next == CTRL_EXEC);

    assign exec.req = (state == CTRL_EXEC);
    assign exe_done = (state == CTRL_DISPLAY);

endmodule

/* operand_entry.sv */
module operand_entry (
    input  logic                  clk,
    input  logic                  rst_n,
    button_if.sink                btn,
    entry_if.sink                 entry,
    exec_if.operands              exec,
    output cal_pkg::bcd_operand_t live_operand
);
    import cal_pkg::*;

    pos_state_t pos;
    bcd_digit_t digit [3];
    logic       sign;
    logic       entry_event;

    function automatic bcd_digit_t step_digit(bcd_digit_t d, logic up);
        if (up) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    assign entry_event = entry.entry_restart | entry.capture_a | entry.capture_b;

    // Position moves left towards the sign, right back to digit 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= POS_IDLE;
        end else if (entry_event) begin
            pos <= POS_IDLE;
        end else begin
            case (pos)
                POS_IDLE:   if (entry.entry_active) pos <= POS_DIGIT0;
                POS_DIGIT0: if (btn.left) pos <= POS_DIGIT1;
                POS_DIGIT1: if (btn.left) pos <= POS_DIGIT2; else if (btn.right) pos <= POS_DIGIT0;
                POS_DIGIT2: if (btn.left) pos <= POS_SIGN; else if (btn.right) pos <= POS_DIGIT1;
                POS_SIGN:   if (btn.right) pos <= POS_DIGIT2;
                default:    pos <= POS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit <= '{default: '0};
            sign  <= 1'b0;
        end else if (entry_event) begin
            digit <= '{default: '0};
            sign  <= 1'b0;
        end else if (btn.up || btn.down) begin
            case (pos)
                POS_DIGIT0: digit[0] <= step_digit(digit[0], btn.up);
                POS_DIGIT1: digit[1] <= step_digit(digit[1], btn.up);
                POS_DIGIT2: digit[2] <= step_digit(digit[2], btn.up);
                POS_SIGN:   sign     <= ~sign;
                default:    ;
            endcase
        end
    end

    assign live_operand = {sign, digit[2], digit[1], digit[0]};

    // Sampled on the same edge that clears the live digits
    always_ff @(posedge clk) begin
        if (entry.capture_a) begin
            exec.operand_a <= live_operand;
        end
        if (entry.capture_b) begin
            exec.operand_b <= live_operand;
        end
    end

endmodule

/* digit_scan.sv */
module digit_scan (
    input  logic                  clk,
    input  logic                  rst_n,
    entry_if.sink                 entry,
    input  cal_pkg::bcd_operand_t live_operand,
    output cal_pkg::digit_sel_t   digit_ctrl,
    output cal_pkg::seg_t         digit_seg
);
    import cal_pkg::*;

    logic [1:0] scan_cnt;
    bcd_digit_t scan_digit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= 2'd0;
        end else if (entry.entry_restart || entry.capture_a || entry.capture_b) begin
            scan_cnt <= 2'd0;
        end else if (entry.entry_active) begin
            scan_cnt <= scan_cnt + 2'd1;
        end
    end

    // Position 3 is the sign, the rest are digits 0 to 2
    assign scan_digit = live_operand[scan_cnt*4 +: 4];

    always_comb begin
        digit_ctrl = 4'b1111;
        digit_seg  = SEG_BLANK;
        if (entry.entry_active) begin
            digit_ctrl = ~(4'b0001 << scan_cnt);
            if (scan_cnt == 2'd3) begin
                digit_seg = live_operand[12] ? SEG_DOT : SEG_BLANK;
            end else if (scan_digit <= 4'd9) begin
                digit_seg = SEG_DIGITS[scan_digit];
            end
        end
    end

endmodule

/* calc_exec.sv */
module calc_exec (
    input  logic             clk,
    input  logic             rst_n,
    exec_if.responder        exec,
    input  cal_pkg::op_sel_t switches,
    output cal_pkg::result_t result,
    output logic             result_invalid
);
    import cal_pkg::*;

    exec_state_t state;
    op_sel_t     op_q;
    op_sel_t     op_first;
    result_t     a_bin;
    result_t     b_bin;
    result_t     op_value;
    logic        invalid;

    function automatic result_t to_binary(bcd_operand_t x);
        result_t mag;
        mag = result_t'(x[11:8]) * result_t'(100)
            + result_t'(x[7:4]) * result_t'(10)
            + result_t'(x[3:0]);
        return x[12] ? -mag : mag;
    endfunction

    assign a_bin = to_binary(exec.operand_a);
    assign b_bin = to_binary(exec.operand_b);

    // Lowest set switch wins
    assign op_first = op_q & (~op_q + 1'b1);
    assign invalid  = (op_first == '0) || (op_first[3] && (b_bin == '0));

    always_comb begin
        op_value = '0;
        case (op_first)
            4'b0001: op_value = result_t'($signed(a_bin) + $signed(b_bin));
            4'b0010: op_value = result_t'($signed(a_bin) - $signed(b_bin));
            4'b0100: op_value = result_t'($signed(a_bin) * $signed(b_bin));
            4'b1000: op_value = result_t'($signed(a_bin) / $signed(b_bin));
            default: op_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == EXEC_IDLE && exec.req) begin
            op_q <= switches;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= EXEC_IDLE;
            result         <= '0;
            result_invalid <= 1'b0;
        end else begin
            case (state)
                EXEC_IDLE: begin
                    if (exec.req) state <= EXEC_INIT;
                end
                EXEC_INIT: begin
                    if (invalid) begin
                        state          <= EXEC_DONE;
                        result         <= '0;
                        result_invalid <= 1'b1;
                    end else begin
                        state <= EXEC_SINGLE;
                    end
                end
                EXEC_SINGLE: begin
                    state          <= EXEC_DONE;
                    result         <= op_value;
                    result_invalid <= 1'b0;
                end
                EXEC_DONE: begin
                    if (!exec.req) state <= EXEC_IDLE;
                end
                default: begin
                    state <= EXEC_IDLE;
                end
            endcase
        end
    end

    assign exec.ack = (state == EXEC_DONE);

endmodule

/* cal_top.sv */
module cal_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [cal_pkg::BUTTON_COUNT-1:0] board_cal_button,
    input  cal_pkg::op_sel_t                 board_cal_switchs,
    output cal_pkg::digit_sel_t              cal_board_digit_ctrl,
    output cal_pkg::seg_t                    cal_board_digit_seg,
    output logic                             cal_board_exe_done,
    output cal_pkg::result_t                 cal_board_result,
    output logic                             cal_board_result_invalid
);
    import cal_pkg::*;

    bcd_operand_t live_operand;

    button_if btn_bus ();
    entry_if  entry_bus ();
    exec_if   exec_bus ();

    button_input u_button_input (
        .clk         (clk),
        .rst_n       (rst_n),
        .raw_buttons (board_cal_button),
        .btn         (btn_bus.source)
    );

    cal_control u_cal_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .btn      (btn_bus.sink),
        .entry    (entry_bus.source),
        .exec     (exec_bus.requester),
        .exe_done (cal_board_exe_done)
    );

    operand_entry u_operand_entry (
        .clk          (clk),
        .rst_n        (rst_n),
        .btn          (btn_bus.sink),
        .entry        (entry_bus.sink),
        .exec         (exec_bus.operands),
        .live_operand (live_operand)
    );

    digit_scan u_digit_scan (
        .clk          (clk),
        .rst_n        (rst_n),
        .entry        (entry_bus.sink),
        .live_operand (live_operand),
        .digit_ctrl   (cal_board_digit_ctrl),
        .digit_seg    (cal_board_digit_seg)
    );

    calc_exec u_calc_exec (
        .clk            (clk),
        .rst_n          (rst_n),
        .exec           (exec_bus.responder),
        .switches       (board_cal_switchs),
        .result         (cal_board_result),
        .result_invalid (cal_board_result_invalid)
    );

endmodule

/* tb_cal_top.sv */
module tb_cal_top;
    import cal_pkg::*;

    localparam int HOLD_CYCLES    = DEBOUNCE_CYCLES + 4;
    localparam int WAIT_LIMIT     = 200;
    localparam int SCAN_POSITIONS = 4;

    logic                    clk = 1'b0;
    logic                    rst_n = 1'b0;
    logic [BUTTON_COUNT-1:0] button;
    op_sel_t                 switches;
    digit_sel_t              digit_ctrl;
    seg_t                    digit_seg;
    logic                    exe_done;
    result_t                 result;
    logic                    result_invalid;

    int         mismatch_count = 0;
    int         timeout_count = 0;
    int         seed = 32'h2936;
    bit         check_en = 1'b1;
    int         model_digit [3];
    bit         model_sign;
    int         model_pos;
    seg_t       exp_seg;
    digit_sel_t prev_ctrl;

    cal_top UUT (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .board_cal_button         (button),
        .board_cal_switchs        (switches),
        .cal_board_digit_ctrl     (digit_ctrl),
        .cal_board_digit_seg      (digit_seg),
        .cal_board_exe_done       (exe_done),
        .cal_board_result         (result),
        .cal_board_result_invalid (result_invalid)
    );

    always #2 clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_ctrl <= 4'b1111;
        end else begin
            prev_ctrl <= digit_ctrl;
        end
    end

    // Expected pattern for whichever position is selected
    always_comb begin
        exp_seg = SEG_BLANK;
        for (int k = 0; k < 3; k++) begin
            if (!digit_ctrl[k]) exp_seg = SEG_DIGITS[model_digit[k]];
        end
        if (!digit_ctrl[3] && model_sign) exp_seg = SEG_DOT;
    end

    one_position_low: assert property (@(posedge clk) disable iff (!rst_n)
        digit_ctrl != 4'b1111 |-> $onehot(~digit_ctrl))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: digit_ctrl expected one low bit, got %b",
                 $time, $sampled(digit_ctrl));
    end

    scan_order: assert property (@(posedge clk) disable iff (!rst_n || !check_en)
        (digit_ctrl != 4'b1111 && prev_ctrl != 4'b1111)
            |-> digit_ctrl == {prev_ctrl[2:0], prev_ctrl[3]})
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: digit_ctrl expected %b, got %b", $time,
                 {$sampled(prev_ctrl[2:0]), $sampled(prev_ctrl[3])}, $sampled(digit_ctrl));
    end

    seg_matches: assert property (@(posedge clk) disable iff (!rst_n || !check_en)
        digit_ctrl != 4'b1111 |-> digit_seg == exp_seg)
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: digit_seg expected %b, got %b", $time,
                 $sampled(exp_seg), $sampled(digit_seg));
    end

    result_holds: assert property (@(posedge clk) disable iff (!rst_n)
        exe_done && $past(exe_done) |-> $stable(result) && $stable(result_invalid))
    else begin
        mismatch_count++;
        $display("Mismatch at %0t: cal_board_result expected %0h, got %0h", $time,
                 $past(result), $sampled(result));
    end

    task automatic next_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic update_model(input logic [BUTTON_COUNT-1:0] mask);
        int idx;
        idx = -1;
        for (int i = BUTTON_COUNT - 1; i >= 0; i--) begin
            if (mask[i]) idx = i;
        end
        if (idx == BTN_MID) begin
            model_digit = '{default: 0};
            model_sign  = 1'b0;
            model_pos   = 0;
        end else if (idx == BTN_LEFT && model_pos < 3) begin
            model_pos++;
        end else if (idx == BTN_RIGHT && model_pos > 0) begin
            model_pos--;
        end else if (idx == BTN_UP || idx == BTN_DOWN) begin
            if (model_pos == 3) begin
                model_sign = !model_sign;
            end else begin
                model_digit[model_pos] = (model_digit[model_pos] + ((idx == BTN_UP) ? 1 : 9)) % 10;
            end
        end
    endtask

    // Display checks pause while a press is debounced, then cover one full scan
    task automatic press_buttons(input logic [BUTTON_COUNT-1:0] mask);
        check_en = 1'b0;
        button   = mask;
        next_cycles(HOLD_CYCLES);
        button   = '0;
        next_cycles(HOLD_CYCLES);
        update_model(mask);
        check_en = 1'b1;
        next_cycles(SCAN_POSITIONS);
    endtask

    task automatic press(input int idx);
        press_buttons(BUTTON_COUNT'(1) << idx);
    endtask

    task automatic wait_entry();
        int cycles;
        cycles = 0;
        while (digit_ctrl == 4'b1111 && cycles < WAIT_LIMIT) begin
            next_cycles(1);
            cycles++;
        end
        if (digit_ctrl == 4'b1111) begin
            timeout_count++;
            $display("Timeout at %0t: display never became active for operand entry", $time);
        end
    endtask

    task automatic wait_exe_done();
        int cycles;
        cycles = 0;
        while (!exe_done && cycles < WAIT_LIMIT) begin
            next_cycles(1);
            cycles++;
        end
        if (!exe_done) begin
            timeout_count++;
            $display("Timeout at %0t: calculation never finished", $time);
        end
    endtask

    function automatic int random_operand();
        return $random(seed) % 1000;
    endfunction

    // Reference model of the operation switches and arithmetic
    task automatic model_operation(input int a, input int b, input op_sel_t sw,
                                   output int value, output bit invalid);
        int op;
        op = -1;
        for (int i = OP_COUNT - 1; i >= 0; i--) begin
            if (sw[i]) op = i;
        end
        invalid = (op < 0) || (op == 3 && b == 0);
        value   = 0;
        if (!invalid) begin
            case (op)
                0:       value = a + b;
                1:       value = a - b;
                2:       value = a * b;
                default: value = a / b;
            endcase
        end
    endtask

    // Shorter direction per digit, then the sign
    task automatic enter_operand(input int value);
        int mag;
        int target;
        int steps;
        mag = (value < 0) ? -value : value;
        while (model_pos > 0) press(BTN_RIGHT);
        for (int k = 0; k < 3; k++) begin
            target = (mag / (10 ** k)) % 10;
            steps  = (target - model_digit[k] + 10) % 10;
            if (steps <= 5) begin
                repeat (steps) press(BTN_UP);
            end else begin
                repeat (10 - steps) press(BTN_DOWN);
            end
            press(BTN_LEFT);
        end
        if (model_sign != (value < 0)) press(BTN_UP);
        press(BTN_RIGHT);
    endtask

    task automatic exercise_editing();
        press(BTN_DOWN);
        press(BTN_UP);
        press(BTN_UP);
        press(BTN_LEFT);
        // Down outranks left
        press_buttons((BUTTON_COUNT'(1) << BTN_DOWN) | (BUTTON_COUNT'(1) << BTN_LEFT));
        press(BTN_RIGHT);
        press(BTN_RIGHT);
        repeat (4) press(BTN_LEFT);
        press(BTN_UP);
        press(BTN_DOWN);
        press(BTN_UP);
    endtask

    task automatic run_calc(input int a, input int b, input op_sel_t sw);
        int exp_value;
        bit exp_invalid;
        if (timeout_count != 0) return;
        enter_operand(a);
        press(BTN_MID);
        enter_operand(b);
        switches = sw;
        press(BTN_MID);
        wait_exe_done();
        if (timeout_count != 0) return;
        model_operation(a, b, sw, exp_value, exp_invalid);
        expect_equal("cal_board_result", 32'(result_t'(exp_value)), 32'(result));
        expect_equal("cal_board_result_invalid", 32'(exp_invalid), 32'(result_invalid));
        press(BTN_MID);
        expect_equal("cal_board_exe_done", 32'd0, 32'(exe_done));
        wait_entry();
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        model_digit = '{default: 0};
        model_sign  = 1'b0;
        model_pos   = 0;
        button      = '0;
        switches    = '0;
        next_cycles(2);
        expect_equal("cal_board_exe_done", 32'd0, 32'(exe_done));
        expect_equal("cal_board_digit_ctrl", 32'hF, 32'(digit_ctrl));
        expect_equal("cal_board_digit_seg", 32'(SEG_BLANK), 32'(digit_seg));
        expect_equal("cal_board_result", 32'd0, 32'(result));
        rst_n = 1'b1;
        wait_entry();
        exercise_editing();
        for (int op = 0; op < OP_COUNT; op++) begin
            run_calc(random_operand(), random_operand(), op_sel_t'(1 << op));
        end
        run_calc(random_operand(), random_operand(), 4'b1100);
        run_calc(random_operand(), random_operand(), 4'b0110);
        run_calc(random_operand(), random_operand(), 4'b1111);
        run_calc(random_operand(), 0, 4'b1000);
        run_calc(random_operand(), 0, 4'b1010);
        run_calc(random_operand(), random_operand(), 4'b0000);
        finish_run();
    end

endmodule

/* cal_top.f */
cal_pkg.sv
cal_if.sv
button_input.sv
cal_control.sv
operand_entry.sv
digit_scan.sv
calc_exec.sv
cal_top.sv
tb_cal_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cal_top \
    -f cal_top.f -o sim_cal_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cal_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
